//--- common/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// 64-byte lines
`define LEN_LINE 6

// 64 sets
`define LEN_INDEX 6

// LRU below is a single bit per set, so this stays at two
`define NR_WAYS 2

`define LEN_TAG (32 - `LEN_LINE - `LEN_INDEX)

`endif

//--- common/ifetch_pkg.sv
`default_nettype none

`include "ifetch_defines.svh"

package ifetch_pkg;

    // l2 tlb reply, even/odd page pair
    typedef struct packed {
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic        c0;
        logic        c1;
        logic        v0;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                valid;
        logic [`LEN_TAG-1:0] tag;
    } icache_tag_t;

    // translation of the current fetch address
    typedef struct packed {
        logic [31:0] pa;
        logic        ok;
        logic        uncached;
    } xlate_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    typedef enum logic [2:0] {
        IDLE,
        FENCE,
        TLB_FILL,
        UNCACHED,
        REFILL,
        SAVE_RESULT
    } ic_state_t;

endpackage

`default_nettype wire

//--- hdl/dual_port_bram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_bram #(
    parameter type payload_t = logic [31:0],
    parameter int  addr_bits = 9
) (
    input  wire                 clk,
    input  wire                 we,
    input  wire [addr_bits-1:0] waddr,
    input  wire payload_t       wdata,
    input  wire [addr_bits-1:0] raddr,
    output payload_t            rdata
);

    payload_t mem [0:(1 << addr_bits) - 1];

    // all-zero contents, so every tag starts invalid
    initial begin
        for (int i = 0; i < (1 << addr_bits); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read-first, old data when both ports hit one address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- i_cache/itlb_translate.sv
`timescale 1ns/1ps
`default_nettype none

module itlb_translate (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [31:0]              inst_va,
    input  wire                     fill,
    input  wire                     itlb_found,
    input  wire ifetch_pkg::tlb_entry_t itlb_entry,
    input  wire                     invalidate,
    output ifetch_pkg::xlate_t      xlate,
    output logic [31:13]            itlb_vpn2,
    output logic                    fill_fault,
    output logic                    fill_refill
);

    logic [31:12] vpn_q;
    logic [19:0]  pfn_q;
    logic         uncached_q;
    logic         valid_q;
    logic         direct;
    logic         page_v;
    logic         page_c;
    logic [19:0]  page_pfn;

    // kseg0 and kseg1
    assign direct = inst_va[31:30] == 2'b10;

    // half of the pair picked by vpn bit 12
    assign page_v = inst_va[12] ? itlb_entry.v1 : itlb_entry.v0;
    assign page_c = inst_va[12] ? itlb_entry.c1 : itlb_entry.c0;
    assign page_pfn = inst_va[12] ? itlb_entry.pfn1 : itlb_entry.pfn0;

    assign itlb_vpn2 = inst_va[31:13];
    assign fill_refill = fill && !itlb_found;
    assign fill_fault = fill && itlb_found && !page_v;

    always_comb begin
        xlate.pa = direct ? {3'b000, inst_va[28:0]} : {pfn_q, inst_va[11:0]};
        xlate.ok = direct || (valid_q && vpn_q == inst_va[31:12]);
        xlate.uncached = direct ? inst_va[29] : uncached_q;
    end

    always_ff @(posedge clk) begin
        if (rst || invalidate) begin
            valid_q <= 1'b0;
        end else if (fill && itlb_found && page_v) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill && itlb_found && page_v) begin
            vpn_q <= inst_va[31:12];
            pfn_q <= page_pfn;
            uncached_q <= !page_c;
        end
    end

endmodule

`default_nettype wire

//--- i_cache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

module icache_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         inst_en,
    input  wire [31:0]                  inst_va,
    input  wire                         stall_f,
    input  wire                         fence_i,
    input  wire [31:0]                  fence_addr,
    input  wire                         fence_tlb,
    input  wire ifetch_pkg::xlate_t     xlate,
    input  wire                         hit,
    input  wire                         hit_way,
    input  wire                         fill_fault,
    input  wire                         fill_refill,
    input  wire                         arready,
    input  wire [31:0]                  rdata,
    input  wire                         rlast,
    input  wire                         rvalid,
    output ifetch_pkg::ic_state_t       state,
    output logic                        istall,
    output logic                        itlb_fill,
    output logic                        itlb_invalidate,
    output ifetch_pkg::axi_ar_t         ar,
    output logic                        arvalid,
    output logic                        rready,
    output logic [`LEN_INDEX-1:0]       wr_line,
    output logic [`LEN_LINE-3:0]        wr_word,
    output logic [2*`NR_WAYS-1:0]       data_we,
    output logic [`NR_WAYS-1:0]         tag_we,
    output ifetch_pkg::icache_tag_t     tag_wdata,
    output logic [31:0]                 saved_inst,
    output logic                        saved_ok,
    output logic                        tlb_refill,
    output logic                        tlb_invalid
);

    import ifetch_pkg::*;

    localparam int IDX_HI = `LEN_LINE + `LEN_INDEX - 1;
    localparam int NR_LINES = 1 << `LEN_INDEX;

    logic [NR_LINES-1:0]   lru;
    logic                  fence_i_rdy;
    logic                  fence_tlb_rdy;
    logic                  fence_i_pend;
    logic                  fence_pend;
    logic                  beat;
    logic [`LEN_INDEX-1:0] va_line;
    logic [`LEN_INDEX-1:0] line_q;
    logic [`LEN_TAG-1:0]   tag_q;
    logic                  fill_way;
    logic [`LEN_LINE-3:0]  beat_cnt;

    assign va_line = inst_va[IDX_HI:`LEN_LINE];
    assign fence_i_pend = fence_i && !fence_i_rdy;
    assign fence_pend = fence_i_pend || (fence_tlb && !fence_tlb_rdy);
    assign beat = rvalid && rready;

    assign itlb_fill = state == TLB_FILL;
    assign itlb_invalidate = state == FENCE;

    always_comb begin
        case (state)
            IDLE: istall = inst_en && (fence_pend || !xlate.ok || xlate.uncached || !hit);
            SAVE_RESULT: istall = 1'b0;
            default: istall = 1'b1;
        endcase
    end

    // fence_i clears the set straight from IDLE, so the FENCE cycle
    // already reads the invalid tags back
    always_comb begin
        wr_line = (state == IDLE) ? fence_addr[IDX_HI:`LEN_LINE] : line_q;
        wr_word = beat_cnt;
        tag_wdata = '0;
        if (state == REFILL) begin
            tag_wdata.valid = 1'b1;
            tag_wdata.tag = tag_q;
        end
        for (int w = 0; w < `NR_WAYS; w++) begin
            tag_we[w] = (state == IDLE && inst_en && fence_i_pend)
                     || (state == REFILL && beat && rlast && fill_way == w);
            for (int b = 0; b < 2; b++) begin
                data_we[2*w+b] = state == REFILL && beat && fill_way == w
                              && beat_cnt[0] == b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            arvalid <= 1'b0;
            rready <= 1'b0;
            tlb_refill <= 1'b0;
            tlb_invalid <= 1'b0;
            saved_ok <= 1'b0;
            fence_i_rdy <= 1'b0;
            fence_tlb_rdy <= 1'b0;
            beat_cnt <= '0;
            lru <= '0;
        end else begin
            // address phase, shared by uncached and refill
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (inst_en) begin
                        if (fence_pend) begin
                            state <= FENCE;
                        end else if (!xlate.ok) begin
                            state <= TLB_FILL;
                        end else if (xlate.uncached) begin
                            ar.addr <= xlate.pa;
                            ar.len <= 8'd0;
                            ar.size <= 3'd2;
                            arvalid <= 1'b1;
                            state <= UNCACHED;
                        end else if (!hit) begin
                            ar.addr <= {xlate.pa[31:`LEN_LINE], {`LEN_LINE{1'b0}}};
                            ar.len <= 8'((1 << (`LEN_LINE - 2)) - 1);
                            ar.size <= 3'd2;
                            arvalid <= 1'b1;
                            line_q <= va_line;
                            tag_q <= xlate.pa[31:IDX_HI+1];
                            fill_way <= lru[va_line];
                            beat_cnt <= '0;
                            state <= REFILL;
                        end else if (!stall_f) begin
                            fence_i_rdy <= 1'b0;
                            fence_tlb_rdy <= 1'b0;
                            // point at the way not just used
                            lru[va_line] <= ~hit_way;
                        end
                    end
                end
                FENCE: begin
                    fence_i_rdy <= 1'b1;
                    fence_tlb_rdy <= 1'b1;
                    state <= IDLE;
                end
                TLB_FILL: begin
                    if (fill_refill || fill_fault) begin
                        tlb_refill <= fill_refill;
                        tlb_invalid <= fill_fault;
                        saved_inst <= '0;
                        saved_ok <= 1'b1;
                        state <= SAVE_RESULT;
                    end else begin
                        state <= IDLE;
                    end
                end
                UNCACHED: begin
                    if (beat) begin
                        saved_inst <= rdata;
                        saved_ok <= 1'b1;
                        rready <= 1'b0;
                        state <= SAVE_RESULT;
                    end
                end
                REFILL: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                        end
                    end else if (!arvalid && !rready) begin
                        // one spare cycle so the last word is readable
                        state <= IDLE;
                    end
                end
                SAVE_RESULT: begin
                    if (!stall_f) begin
                        fence_i_rdy <= 1'b0;
                        fence_tlb_rdy <= 1'b0;
                        tlb_refill <= 1'b0;
                        tlb_invalid <= 1'b0;
                        saved_ok <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- i_cache/icache_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

module icache_result (
    input  wire                          inst_en,
    input  wire [31:0]                   inst_va,
    input  wire ifetch_pkg::xlate_t      xlate,
    input  wire ifetch_pkg::ic_state_t   state,
    input  wire ifetch_pkg::icache_tag_t tag0,
    input  wire ifetch_pkg::icache_tag_t tag1,
    input  wire [31:0]                   word0_lo,
    input  wire [31:0]                   word0_hi,
    input  wire [31:0]                   word1_lo,
    input  wire [31:0]                   word1_hi,
    input  wire [31:0]                   saved_inst,
    input  wire                          saved_ok,
    input  wire                          istall,
    output logic                         hit,
    output logic                         hit_way,
    output logic [31:0]                  inst_rdata0,
    output logic [31:0]                  inst_rdata1,
    output logic                         inst_ok0,
    output logic                         inst_ok1
);

    import ifetch_pkg::*;

    logic [`LEN_TAG-1:0] ptag;
    logic                way0_hit;
    logic                way1_hit;
    logic [31:0]         sel_lo;
    logic [31:0]         sel_hi;

    assign ptag = xlate.pa[31:32-`LEN_TAG];
    assign way0_hit = tag0.valid && tag0.tag == ptag;
    assign way1_hit = tag1.valid && tag1.tag == ptag;
    assign hit = way0_hit || way1_hit;
    assign hit_way = way1_hit;

    assign sel_lo = hit_way ? word1_lo : word0_lo;
    assign sel_hi = hit_way ? word1_hi : word0_hi;

    always_comb begin
        if (state == IDLE) begin
            inst_rdata0 = inst_va[2] ? sel_hi : sel_lo;
            inst_rdata1 = sel_hi;
            inst_ok0 = inst_en && !istall;
            // second word only from an even address
            inst_ok1 = inst_en && !istall && !inst_va[2];
        end else begin
            inst_rdata0 = saved_inst;
            inst_rdata1 = '0;
            inst_ok0 = inst_en && !istall && saved_ok;
            inst_ok1 = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_defines.svh"

module ifetch_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         inst_en,
    input  wire [31:0]                  inst_va,
    input  wire [31:0]                  inst_va_next,
    input  wire                         stall_f,
    input  wire                         fence_i,
    input  wire [31:0]                  fence_addr,
    input  wire                         fence_tlb,
    output wire [31:0]                  inst_rdata0,
    output wire [31:0]                  inst_rdata1,
    output wire                         inst_ok0,
    output wire                         inst_ok1,
    output wire                         istall,
    output wire                         tlb_refill,
    output wire                         tlb_invalid,
    output wire [31:13]                 itlb_vpn2,
    input  wire                         itlb_found,
    input  wire ifetch_pkg::tlb_entry_t itlb_entry,
    output wire ifetch_pkg::axi_ar_t    ar,
    output wire                         arvalid,
    input  wire                         arready,
    input  wire [31:0]                  rdata,
    input  wire                         rlast,
    input  wire                         rvalid,
    output wire                         rready
);

    import ifetch_pkg::*;

    localparam int IDX_HI = `LEN_LINE + `LEN_INDEX - 1;
    localparam int DATA_BITS = `LEN_INDEX + `LEN_LINE - 3;

    xlate_t                xlate;
    ic_state_t             state;
    logic                  hit;
    logic                  hit_way;
    logic                  itlb_fill;
    logic                  itlb_invalidate;
    logic                  fill_fault;
    logic                  fill_refill;
    logic [`LEN_INDEX-1:0] wr_line;
    logic [`LEN_LINE-3:0]  wr_word;
    logic [2*`NR_WAYS-1:0] data_we;
    logic [`NR_WAYS-1:0]   tag_we;
    icache_tag_t           tag_wdata;
    logic [31:0]           saved_inst;
    logic                  saved_ok;
    logic [31:0]           word_lo [`NR_WAYS];
    logic [31:0]           word_hi [`NR_WAYS];
    icache_tag_t           tag_rd [`NR_WAYS];
    wire  [31:0]           rd_va;

    // look one address ahead while a new fetch can start
    assign rd_va = (state == IDLE || state == SAVE_RESULT) ? inst_va_next : inst_va;

    itlb_translate u_xlate (
        .clk        (clk),
        .rst        (rst),
        .inst_va    (inst_va),
        .fill       (itlb_fill),
        .itlb_found (itlb_found),
        .itlb_entry (itlb_entry),
        .invalidate (itlb_invalidate),
        .xlate      (xlate),
        .itlb_vpn2  (itlb_vpn2),
        .fill_fault (fill_fault),
        .fill_refill(fill_refill)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .inst_en        (inst_en),
        .inst_va        (inst_va),
        .stall_f        (stall_f),
        .fence_i        (fence_i),
        .fence_addr     (fence_addr),
        .fence_tlb      (fence_tlb),
        .xlate          (xlate),
        .hit            (hit),
        .hit_way        (hit_way),
        .fill_fault     (fill_fault),
        .fill_refill    (fill_refill),
        .arready        (arready),
        .rdata          (rdata),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .state          (state),
        .istall         (istall),
        .itlb_fill      (itlb_fill),
        .itlb_invalidate(itlb_invalidate),
        .ar             (ar),
        .arvalid        (arvalid),
        .rready         (rready),
        .wr_line        (wr_line),
        .wr_word        (wr_word),
        .data_we        (data_we),
        .tag_we         (tag_we),
        .tag_wdata      (tag_wdata),
        .saved_inst     (saved_inst),
        .saved_ok       (saved_ok),
        .tlb_refill     (tlb_refill),
        .tlb_invalid    (tlb_invalid)
    );

    icache_result u_result (
        .inst_en    (inst_en),
        .inst_va    (inst_va),
        .xlate      (xlate),
        .state      (state),
        .tag0       (tag_rd[0]),
        .tag1       (tag_rd[1]),
        .word0_lo   (word_lo[0]),
        .word0_hi   (word_hi[0]),
        .word1_lo   (word_lo[1]),
        .word1_hi   (word_hi[1]),
        .saved_inst (saved_inst),
        .saved_ok   (saved_ok),
        .istall     (istall),
        .hit        (hit),
        .hit_way    (hit_way),
        .inst_rdata0(inst_rdata0),
        .inst_rdata1(inst_rdata1),
        .inst_ok0   (inst_ok0),
        .inst_ok1   (inst_ok1)
    );

    // per way, even words in lo, odd words in hi, plus the tag RAM
    for (genvar w = 0; w < `NR_WAYS; w++) begin : g_way
        dual_port_bram #(.payload_t(logic [31:0]), .addr_bits(DATA_BITS)) u_lo (
            .clk  (clk),
            .we   (data_we[2*w]),
            .waddr({wr_line, wr_word[`LEN_LINE-3:1]}),
            .wdata(rdata),
            .raddr(rd_va[IDX_HI:3]),
            .rdata(word_lo[w])
        );

        dual_port_bram #(.payload_t(logic [31:0]), .addr_bits(DATA_BITS)) u_hi (
            .clk  (clk),
            .we   (data_we[2*w+1]),
            .waddr({wr_line, wr_word[`LEN_LINE-3:1]}),
            .wdata(rdata),
            .raddr(rd_va[IDX_HI:3]),
            .rdata(word_hi[w])
        );

        dual_port_bram #(.payload_t(icache_tag_t), .addr_bits(`LEN_INDEX)) u_tag (
            .clk  (clk),
            .we   (tag_we[w]),
            .waddr(wr_line),
            .wdata(tag_wdata),
            .raddr(rd_va[IDX_HI:`LEN_LINE]),
            .rdata(tag_rd[w])
        );
    end

endmodule

`default_nettype wire

//--- tests/ifetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_chk (
    input wire clk,
    input wire rst,
    input wire arvalid,
    input wire arready,
    input wire rready,
    input wire inst_ok0,
    input wire inst_ok1,
    input wire tlb_refill,
    input wire tlb_invalid
);

    // address phase held until taken
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(rready && arvalid))
        else $error("rready and arvalid high together");

    // second word never without the first
    a_ok_order: assert property (@(posedge clk) disable iff (rst)
        inst_ok1 |-> inst_ok0)
        else $error("inst_ok1 without inst_ok0");

    a_one_exc: assert property (@(posedge clk) disable iff (rst)
        !(tlb_refill && tlb_invalid))
        else $error("tlb_refill and tlb_invalid high together");

endmodule

bind ifetch_top ifetch_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .arvalid    (arvalid),
    .arready    (arready),
    .rready     (rready),
    .inst_ok0   (inst_ok0),
    .inst_ok1   (inst_ok1),
    .tlb_refill (tlb_refill),
    .tlb_invalid(tlb_invalid)
);

`default_nettype wire

//--- tests/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

    import ifetch_pkg::*;

    localparam int NR_TESTS = 6;
    localparam int NR_RANDOM = 150;

    logic        clk;
    logic        rst;
    logic        inst_en;
    logic [31:0] inst_va;
    logic [31:0] inst_va_next;
    logic        stall_f;
    logic        fence_i;
    logic [31:0] fence_addr;
    logic        fence_tlb;
    logic        itlb_found;
    tlb_entry_t  itlb_entry;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic [31:0] inst_rdata0;
    logic [31:0] inst_rdata1;
    logic        inst_ok0;
    logic        inst_ok1;
    logic        istall;
    logic        tlb_refill;
    logic        tlb_invalid;
    logic [31:13] itlb_vpn2;
    axi_ar_t     ar;
    logic        arvalid;
    logic        rready;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          err0;
    int          chk0;
    string       test_name;

    // memory model state
    logic        have_req;
    logic [31:0] req_addr;
    logic [7:0]  req_len;
    logic [7:0]  beat_idx;
    int          nr_bursts;
    int          nr_singles;
    logic [31:0] last_addr;
    logic [7:0]  last_len;

    // l2 tlb contents
    logic [31:13] tbl_vpn2 [4];
    tlb_entry_t   tbl_entry [4];
    logic [31:0]  addr_q [$];

    ifetch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_comb begin
        itlb_found = 1'b0;
        itlb_entry = '0;
        for (int i = 0; i < 4; i++) begin
            if (tbl_vpn2[i] == itlb_vpn2) begin
                itlb_found = 1'b1;
                itlb_entry = tbl_entry[i];
            end
        end
    end

    task automatic check(input string what, input logic [71:0] expected,
                         input logic [71:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] pa);
        return (pa * 32'h9e3779b1) ^ {pa[15:0], pa[31:16]};
    endfunction

    // one AXI slave cycle decided on the falling edge
    task automatic axi_step;
        if (!have_req) begin
            rvalid = 1'b0;
            rlast = 1'b0;
            arready = $random(seed) & 1;
            if (arvalid && arready) begin
                have_req = 1'b1;
                req_addr = ar.addr;
                req_len = ar.len;
                beat_idx = '0;
                last_addr = ar.addr;
                last_len = ar.len;
                // every beat carries one 32-bit word
                check("ar size", 3'd2, ar.size);
                if (ar.len == 8'd15) nr_bursts++;
                if (ar.len == 8'd0) nr_singles++;
            end
        end else begin
            arready = 1'b0;
            rvalid = rready && (($random(seed) & 3) != 0);
            rdata = word_at(req_addr + {22'd0, beat_idx, 2'b00});
            rlast = beat_idx == req_len;
            if (rvalid) begin
                beat_idx++;
                if (rlast) have_req = 1'b0;
            end
        end
    endtask

    task automatic next_cycle;
        @(negedge clk);
        axi_step();
    endtask

    // expected fetch result from the address map and the l2 table
    task automatic model(input logic [31:0] va, output logic [31:0] d0, output logic [31:0] d1,
                         output logic ok1, output logic refill, output logic invalid);
        logic [31:0] pa;
        logic        unc;
        logic        found;
        tlb_entry_t  e;
        d0 = '0;
        d1 = '0;
        ok1 = 1'b0;
        refill = 1'b0;
        invalid = 1'b0;
        found = 1'b0;
        e = '0;
        if (va[31:30] == 2'b10) begin
            pa = {3'b000, va[28:0]};
            unc = va[29];
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (tbl_vpn2[i] == va[31:13]) begin
                    found = 1'b1;
                    e = tbl_entry[i];
                end
            end
            refill = !found;
            invalid = found && !(va[12] ? e.v1 : e.v0);
            pa = {(va[12] ? e.pfn1 : e.pfn0), va[11:0]};
            unc = !(va[12] ? e.c1 : e.c0);
        end
        if (!refill && !invalid) begin
            d0 = word_at(pa);
            ok1 = !unc && !va[2];
            d1 = ok1 ? word_at(pa + 32'd4) : '0;
        end
    endtask

    // fetches addr_q in order with fences held until the first accept
    task automatic run_fetches(input logic random_stall, input logic with_fence_i,
                               input logic with_fence_tlb);
        logic        accepted;
        logic        held;
        logic [67:0] snap;
        logic [67:0] prev;
        logic [31:0] e0;
        logic [31:0] e1;
        logic        eok1;
        logic        eref;
        logic        einv;
        held = 1'b0;
        prev = '0;
        next_cycle();
        inst_en = 1'b0;
        stall_f = 1'b0;
        inst_va = addr_q[0];
        inst_va_next = addr_q[0];
        fence_i = with_fence_i;
        fence_addr = addr_q[0];
        fence_tlb = with_fence_tlb;
        foreach (addr_q[i]) begin
            accepted = 1'b0;
            while (!accepted) begin
                next_cycle();
                if (i > 0) begin
                    fence_i = 1'b0;
                    fence_tlb = 1'b0;
                end
                inst_en = 1'b1;
                inst_va = addr_q[i];
                stall_f = random_stall && (($random(seed) & 3) == 0);
                #1;
                snap = {inst_rdata0, inst_rdata1, inst_ok0, inst_ok1, tlb_refill, tlb_invalid};
                if (held) check("held outputs", prev, snap);
                held = inst_ok0 && !istall && stall_f;
                prev = snap;
                accepted = inst_ok0 && !istall && !stall_f;
                if (accepted) begin
                    model(addr_q[i], e0, e1, eok1, eref, einv);
                    check("inst_rdata0", e0, inst_rdata0);
                    if (eok1) check("inst_rdata1", e1, inst_rdata1);
                    check("inst_ok1", eok1, inst_ok1);
                    check("tlb_refill", eref, tlb_refill);
                    check("tlb_invalid", einv, tlb_invalid);
                    inst_va_next = (i + 1 < addr_q.size()) ? addr_q[i+1] : addr_q[i];
                end
            end
        end
        next_cycle();
        inst_en = 1'b0;
        stall_f = 1'b0;
        fence_i = 1'b0;
        fence_tlb = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err0 = errors;
        chk0 = checks;
        addr_q = {};
    endtask

    task automatic end_test;
        tests++;
        $display("%s: %0d checks, %0d mismatches", test_name, checks - chk0, errors - err0);
    endtask

    initial begin
        logic [63:0] rnd;
        logic [31:0] r;
        logic [31:0] va;
        int          b0;
        int          s0;
        seed = 32'ha491d199;
        errors = 0;
        checks = 0;
        tests = 0;
        rst = 1'b1;
        inst_en = 1'b0;
        inst_va = '0;
        inst_va_next = '0;
        stall_f = 1'b0;
        fence_i = 1'b0;
        fence_addr = '0;
        fence_tlb = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        rvalid = 1'b0;
        have_req = 1'b0;
        nr_bursts = 0;
        nr_singles = 0;
        last_addr = '0;
        last_len = '0;
        // even page cached and odd page uncached
        tbl_vpn2[0] = 19'h00010;
        tbl_entry[0] = '{pfn0: 20'h12345, pfn1: 20'h23456, c0: 1'b1, c1: 1'b0,
                         v0: 1'b1, v1: 1'b1};
        // even page invalid
        tbl_vpn2[1] = 19'h00020;
        tbl_entry[1] = '{pfn0: 20'h0, pfn1: 20'h34567, c0: 1'b1, c1: 1'b1,
                         v0: 1'b0, v1: 1'b1};
        for (int i = 2; i < 4; i++) begin
            rnd = {$random(seed), $random(seed)};
            tbl_vpn2[i] = 19'h0002e + 19'(i);
            tbl_entry[i] = rnd[43:0];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("kseg0_fetch");
        b0 = nr_bursts;
        addr_q = {32'h80002008};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 1, nr_bursts - b0);
        check("burst addr", 32'h00002000, last_addr);
        check("burst len", 8'd15, last_len);
        addr_q = {};
        for (int i = 0; i < 16; i++) addr_q.push_back(32'h80002000 + 4 * i);
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 1, nr_bursts - b0);
        addr_q = {};
        for (int i = 0; i < 20; i++) addr_q.push_back(32'h80001000 + 4 * i);
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 3, nr_bursts - b0);
        check("burst addr", 32'h00001040, last_addr);
        end_test();

        start_test("kseg1_uncached");
        s0 = nr_singles;
        addr_q = {32'ha0003004, 32'ha0003010, 32'ha0003004};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("single reads", 3, nr_singles - s0);
        check("read addr", 32'h00003004, last_addr);
        end_test();

        start_test("mapped");
        s0 = nr_singles;
        b0 = nr_bursts;
        addr_q = {32'h00020010, 32'h00020014, 32'h00021020, 32'h00040000,
                  32'h00100000, 32'h00041008};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("single reads", 1, nr_singles - s0);
        check("bursts", 2, nr_bursts - b0);
        end_test();

        start_test("lru");
        b0 = nr_bursts;
        addr_q = {32'h80010100, 32'h80020100, 32'h80010100, 32'h80030100};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 3, nr_bursts - b0);
        addr_q = {32'h80010100, 32'h80030100};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 3, nr_bursts - b0);
        addr_q = {32'h80020100};
        run_fetches(1'b1, 1'b0, 1'b0);
        check("bursts", 4, nr_bursts - b0);
        end_test();

        start_test("fences");
        b0 = nr_bursts;
        addr_q = {32'h80030100};
        run_fetches(1'b0, 1'b1, 1'b0);
        check("bursts", 1, nr_bursts - b0);
        addr_q = {32'h00020010};
        run_fetches(1'b0, 1'b0, 1'b0);
        // new table content that the L1 entry still hides
        tbl_entry[0].pfn0 = 20'h0abcd;
        addr_q = {32'h00020014};
        run_fetches(1'b0, 1'b0, 1'b1);
        check("refetch addr", 32'h0abcd000, last_addr);
        end_test();

        start_test("random_stream");
        va = 32'h80000000;
        for (int n = 0; n < NR_RANDOM; n++) begin
            r = $random(seed);
            if (r[0]) begin
                va = va + 32'd4;
            end else begin
                case (r[5:4])
                    2'd0: va = 32'h80000000 + {18'd0, r[19:8], 2'b00};
                    2'd1: va = 32'ha0000000 + {18'd0, r[19:8], 2'b00};
                    2'd2: va = {tbl_vpn2[r[7:6]], r[20:10], 2'b00};
                    default: va = {19'h00077, r[20:10], 2'b00};
                endcase
            end
            addr_q.push_back(va);
        end
        run_fetches(1'b1, 1'b0, 1'b0);
        end_test();

        $display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog scaled to the number of tests
    initial begin
        repeat (NR_TESTS * 2000) @(posedge clk);
        $display("timeout: fetch never completed in %s", test_name);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_ifetch.f
+incdir+common
common/ifetch_pkg.sv
hdl/dual_port_bram.sv
i_cache/itlb_translate.sv
i_cache/icache_ctrl.sv
i_cache/icache_result.sv
hdl/ifetch_top.sv
tests/ifetch_chk.sv
tests/ifetch_tb.sv

//--- Makefile
TOP = ifetch_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mips_ifetch.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f mips_ifetch.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
